//--- include/gfx_consts.svh
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// memory geometry
`define ADDR_W       17
`define DATA_W       32
`define WBEN_W       4
`define NUM_CLIENTS  3

// command field widths
`define COORD_W      8
`define OP_W         4

// command list start and frame base
// a pixel lives at FB_BASE + y*256 + x
`define CMD_BASE     17'h00000
`define FB_BASE      17'h10000

// opcodes
`define OP_END       4'd0
`define OP_FILL      4'd1
`define OP_COPY      4'd2

// other-client grants a waiting fetcher tolerates before it is forced in
`define FETCH_STARVE 1

`endif

//--- verilog/mem_pkg.sv
`include "gfx_consts.svh"

package mem_pkg;

    // word address into the frame memory
    typedef logic [`ADDR_W-1:0] addr_t;

    // one memory word, also one pixel
    typedef logic [`DATA_W-1:0] data_t;

    // byte write enables, zero is a read
    typedef logic [`WBEN_W-1:0] wben_t;

    // one-hot client vector
    // bit 0 fetcher, bit 1 fill engine, bit 2 copy engine
    typedef logic [`NUM_CLIENTS-1:0] client_t;

    // what a client presents to the arbiter
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        wben_t wben;
    } mem_req_t;

endpackage

//--- verilog/cmd_pkg.sv
`include "gfx_consts.svh"

package cmd_pkg;

    // pixel coordinate or rectangle size
    typedef logic [`COORD_W-1:0] coord_t;

    typedef logic [`OP_W-1:0] opcode_t;

    // one decoded command
    // arg is the colour for a fill, {sy, sx} in the low half for a copy
    typedef struct packed {
        opcode_t                op;
        coord_t                 w;
        coord_t                 h;
        coord_t                 dx;
        coord_t                 dy;
        logic [`DATA_W-1:0]     arg;
    } rect_cmd_t;

endpackage

//--- verilog/cmd_fetch.sv
`include "gfx_consts.svh"

module cmd_fetch
    import mem_pkg::*;
    import cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_,
    input  logic      start,
    output logic      busy,
    output logic      done,
    output mem_req_t  req,
    output logic      rts,
    input  logic      rtr,
    input  data_t     bcast_data,
    input  logic      bcast_xfc_own,
    output logic      fill_go,
    output logic      copy_go,
    output rect_cmd_t cmd,
    input  logic      fill_done,
    input  logic      copy_done
);

    typedef enum logic [2:0] {
        S_IDLE, S_READ, S_WAIT, S_DISPATCH, S_ENGINE, S_FINISH
    } state_t;

    state_t    state;
    addr_t     ptr;
    logic [1:0] word_idx;
    rect_cmd_t cmd_q;

    // reads only, so wdata and wben stay zero
    always_comb begin
        req      = '0;
        req.addr = ptr;
    end

    assign rts     = (state == S_READ);
    assign busy    = (state != S_IDLE);
    assign done    = (state == S_FINISH);
    assign fill_go = (state == S_DISPATCH) && (cmd_q.op == `OP_FILL);
    assign copy_go = (state == S_DISPATCH) && (cmd_q.op == `OP_COPY);
    assign cmd     = cmd_q;

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            state    <= S_IDLE;
            ptr      <= `CMD_BASE;
            word_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        ptr      <= `CMD_BASE;
                        word_idx <= '0;
                        state    <= S_READ;
                    end
                end
                // rts is up here, so rtr alone means the read went out
                S_READ: begin
                    if (rtr) begin
                        ptr   <= ptr + 1'b1;
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (bcast_xfc_own) begin
                        if (word_idx == 2'd2) begin
                            word_idx <= '0;
                            state    <= S_DISPATCH;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            state    <= S_READ;
                        end
                    end
                end
                S_DISPATCH: begin
                    case (cmd_q.op)
                        `OP_END:           state <= S_FINISH;
                        `OP_FILL, `OP_COPY: state <= S_ENGINE;
                        // unknown opcode, move on to the next command
                        default:           state <= S_READ;
                    endcase
                end
                S_ENGINE: begin
                    if (fill_done || copy_done) begin
                        state <= S_READ;
                    end
                end
                S_FINISH: state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // assemble the command as its words come back
    always_ff @(posedge clk) begin
        if (state == S_WAIT && bcast_xfc_own) begin
            case (word_idx)
                2'd0: begin
                    cmd_q.op <= bcast_data[31:28];
                    cmd_q.w  <= bcast_data[15:8];
                    cmd_q.h  <= bcast_data[7:0];
                end
                2'd1: begin
                    cmd_q.dy <= bcast_data[15:8];
                    cmd_q.dx <= bcast_data[7:0];
                end
                default: cmd_q.arg <= bcast_data;
            endcase
        end
    end

endmodule

//--- verilog/rect_fill.sv
`include "gfx_consts.svh"

module rect_fill
    import mem_pkg::*;
    import cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_,
    input  logic      go,
    input  rect_cmd_t cmd,
    output mem_req_t  req,
    output logic      rts,
    input  logic      rtr,
    output logic      done
);

    typedef enum logic [1:0] {F_IDLE, F_RUN, F_DONE} state_t;

    state_t    state;
    rect_cmd_t cmd_q;
    coord_t    x;
    coord_t    y;
    coord_t    px;
    coord_t    py;

    // coordinates wrap inside the frame, no clipping
    assign px = cmd_q.dx + x;
    assign py = cmd_q.dy + y;

    // full word write of the colour
    always_comb begin
        req.addr  = `FB_BASE + addr_t'({py, px});
        req.wdata = cmd_q.arg;
        req.wben  = '1;
    end

    assign rts  = (state == F_RUN);
    assign done = (state == F_DONE);

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            state <= F_IDLE;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (go) begin
                        x     <= '0;
                        y     <= '0;
                        // empty rectangle finishes right away
                        state <= (cmd.w == '0 || cmd.h == '0) ? F_DONE : F_RUN;
                    end
                end
                // row order, x fastest
                F_RUN: begin
                    if (rtr) begin
                        if (x == cmd_q.w - 1'b1) begin
                            x <= '0;
                            if (y == cmd_q.h - 1'b1) begin
                                state <= F_DONE;
                            end else begin
                                y <= y + 1'b1;
                            end
                        end else begin
                            x <= x + 1'b1;
                        end
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            cmd_q <= cmd;
        end
    end

endmodule

//--- verilog/rect_copy.sv
`include "gfx_consts.svh"

module rect_copy
    import mem_pkg::*;
    import cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_,
    input  logic      go,
    input  rect_cmd_t cmd,
    output mem_req_t  req,
    output logic      rts,
    input  logic      rtr,
    output logic      done,
    input  data_t     bcast_data,
    input  logic      bcast_xfc_own
);

    typedef enum logic [2:0] {C_IDLE, C_RD, C_RD_WAIT, C_WR, C_DONE} state_t;

    state_t    state;
    rect_cmd_t cmd_q;
    coord_t    x;
    coord_t    y;
    data_t     pix;
    addr_t     src_addr;
    addr_t     dst_addr;

    // source y and x sit in the low half of arg
    assign src_addr = `FB_BASE + addr_t'({coord_t'(cmd_q.arg[15:8] + y),
                                          coord_t'(cmd_q.arg[7:0] + x)});
    assign dst_addr = `FB_BASE + addr_t'({coord_t'(cmd_q.dy + y),
                                          coord_t'(cmd_q.dx + x)});

    // read the source, then write the captured pixel to the destination
    always_comb begin
        req.addr  = (state == C_WR) ? dst_addr : src_addr;
        req.wdata = pix;
        req.wben  = (state == C_WR) ? '1 : '0;
    end

    assign rts  = (state == C_RD) || (state == C_WR);
    assign done = (state == C_DONE);

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            state <= C_IDLE;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (go) begin
                        x     <= '0;
                        y     <= '0;
                        state <= (cmd.w == '0 || cmd.h == '0) ? C_DONE : C_RD;
                    end
                end
                C_RD: begin
                    if (rtr) begin
                        state <= C_RD_WAIT;
                    end
                end
                C_RD_WAIT: begin
                    if (bcast_xfc_own) begin
                        state <= C_WR;
                    end
                end
                // write accepted, step to the next pixel in row order
                C_WR: begin
                    if (rtr) begin
                        state <= C_RD;
                        if (x == cmd_q.w - 1'b1) begin
                            x <= '0;
                            if (y == cmd_q.h - 1'b1) begin
                                state <= C_DONE;
                            end else begin
                                y <= y + 1'b1;
                            end
                        end else begin
                            x <= x + 1'b1;
                        end
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            cmd_q <= cmd;
        end
        if (state == C_RD_WAIT && bcast_xfc_own) begin
            pix <= bcast_data;
        end
    end

endmodule

//--- verilog/mem_arbiter.sv
`include "gfx_consts.svh"

module mem_arbiter
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_,
    input  mem_req_t fetch_req,
    input  logic     fetch_rts,
    output logic     fetch_rtr,
    input  mem_req_t fill_req,
    input  logic     fill_rts,
    output logic     fill_rtr,
    input  mem_req_t copy_req,
    input  logic     copy_rts,
    output logic     copy_rtr,
    output addr_t    mem_addr,
    output data_t    mem_wdata,
    output wben_t    mem_wben,
    input  data_t    mem_rdata,
    output data_t    bcast_data,
    output client_t  bcast_xfc
);

    client_t    rts_vec;
    client_t    sel;
    client_t    sel_nxt;
    client_t    xfc;
    client_t    rr;
    client_t    next_rr;
    client_t    prio;
    client_t    rd_tag;
    logic [1:0] starve_cnt;
    mem_req_t   sel_req;

    assign rts_vec = {copy_rts, fill_rts, fetch_rts};

    // each client is ready when its bit of the registered selection is set
    assign fetch_rtr = sel[0];
    assign fill_rtr  = sel[1];
    assign copy_rtr  = sel[2];
    assign xfc       = sel & rts_vec;

    // turn pointer rotates one client per cycle
    assign next_rr = {rr[1:0], rr[2]};

    // fixed priority, fetcher first
    always_comb begin
        casez (rts_vec)
            3'b??1:  prio = 3'b001;
            3'b?10:  prio = 3'b010;
            3'b100:  prio = 3'b100;
            default: prio = '0;
        endcase
    end

    // starving fetcher wins, else the turn if it has a request, else priority
    always_comb begin
        if (fetch_rts && starve_cnt >= `FETCH_STARVE) begin
            sel_nxt = 3'b001;
        end else if (|(rts_vec & rr)) begin
            sel_nxt = rr;
        end else begin
            sel_nxt = prio;
        end
    end

    // request of the selected client
    always_comb begin
        case (sel)
            3'b010:  sel_req = fill_req;
            3'b100:  sel_req = copy_req;
            default: sel_req = fetch_req;
        endcase
    end

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            sel        <= '0;
            rr         <= 3'b001;
            starve_cnt <= '0;
            mem_wben   <= '0;
            rd_tag     <= '0;
            bcast_xfc  <= '0;
        end else begin
            sel <= sel_nxt;
            rr  <= next_rr;
            // count turns the waiting fetcher was passed over
            if (!fetch_rts || sel_nxt[0]) begin
                starve_cnt <= '0;
            end else begin
                starve_cnt <= starve_cnt + 1'b1;
            end
            // selected but idle client gives a no-op cycle
            mem_wben <= (|xfc) ? sel_req.wben : '0;
            // tag reads so the data goes back to the right client
            rd_tag    <= (|xfc && sel_req.wben == '0) ? xfc : '0;
            // memory data arrives one cycle after the registered address
            bcast_xfc <= rd_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (|xfc) begin
            mem_addr  <= sel_req.addr;
            mem_wdata <= sel_req.wdata;
        end
    end

    assign bcast_data = mem_rdata;

endmodule

//--- verilog/frame_mem.sv
`include "gfx_consts.svh"

module frame_mem
    import mem_pkg::*;
(
    input  logic  clk,
    input  addr_t a_addr,
    input  data_t a_wdata,
    input  wben_t a_wben,
    output data_t a_rdata,
    input  logic  b_we,
    input  addr_t b_addr,
    input  data_t b_wdata,
    output data_t b_rdata
);

    data_t mem [0:(1 << `ADDR_W)-1];

    // both ports read first; no same-address writes from the two sides
    always_ff @(posedge clk) begin
        for (int i = 0; i < `WBEN_W; i++) begin
            if (a_wben[i]) begin
                mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
            end
        end
        // host side writes whole words
        if (b_we) begin
            mem[b_addr] <= b_wdata;
        end
        a_rdata <= mem[a_addr];
        b_rdata <= mem[b_addr];
    end

endmodule

//--- verilog/gfx_top.sv
module gfx_top
    import mem_pkg::*;
    import cmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst_,
    input  logic  start,
    output logic  busy,
    output logic  done,
    input  logic  host_we,
    input  addr_t host_addr,
    input  data_t host_wdata,
    output data_t host_rdata
);

    mem_req_t  fetch_req;
    mem_req_t  fill_req;
    mem_req_t  copy_req;
    logic      fetch_rts;
    logic      fetch_rtr;
    logic      fill_rts;
    logic      fill_rtr;
    logic      copy_rts;
    logic      copy_rtr;
    addr_t     mem_addr;
    data_t     mem_wdata;
    wben_t     mem_wben;
    data_t     mem_rdata;
    data_t     bcast_data;
    client_t   bcast_xfc;
    logic      fill_go;
    logic      copy_go;
    logic      fill_done;
    logic      copy_done;
    rect_cmd_t cmd;

    // fetcher is client 0
    cmd_fetch u_fetch (
        .clk(clk), .rst_(rst_), .start(start), .busy(busy), .done(done),
        .req(fetch_req), .rts(fetch_rts), .rtr(fetch_rtr),
        .bcast_data(bcast_data), .bcast_xfc_own(bcast_xfc[0]),
        .fill_go(fill_go), .copy_go(copy_go), .cmd(cmd),
        .fill_done(fill_done), .copy_done(copy_done)
    );

    // fill engine is client 1, writes only
    rect_fill u_fill (
        .clk(clk), .rst_(rst_), .go(fill_go), .cmd(cmd),
        .req(fill_req), .rts(fill_rts), .rtr(fill_rtr), .done(fill_done)
    );

    // copy engine is client 2
    rect_copy u_copy (
        .clk(clk), .rst_(rst_), .go(copy_go), .cmd(cmd),
        .req(copy_req), .rts(copy_rts), .rtr(copy_rtr), .done(copy_done),
        .bcast_data(bcast_data), .bcast_xfc_own(bcast_xfc[2])
    );

    mem_arbiter u_arb (
        .clk(clk), .rst_(rst_),
        .fetch_req(fetch_req), .fetch_rts(fetch_rts), .fetch_rtr(fetch_rtr),
        .fill_req(fill_req), .fill_rts(fill_rts), .fill_rtr(fill_rtr),
        .copy_req(copy_req), .copy_rts(copy_rts), .copy_rtr(copy_rtr),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wben(mem_wben),
        .mem_rdata(mem_rdata), .bcast_data(bcast_data), .bcast_xfc(bcast_xfc)
    );

    // port a for the engines, port b for the host
    frame_mem u_mem (
        .clk(clk),
        .a_addr(mem_addr), .a_wdata(mem_wdata), .a_wben(mem_wben), .a_rdata(mem_rdata),
        .b_we(host_we), .b_addr(host_addr), .b_wdata(host_wdata), .b_rdata(host_rdata)
    );

endmodule

//--- tb/gfx_checker.sv
`include "gfx_consts.svh"

module gfx_checker
    import mem_pkg::*;
(
    input logic     clk,
    input logic     rst_,
    input mem_req_t fetch_req,
    input logic     fetch_rts,
    input logic     fetch_rtr,
    input mem_req_t fill_req,
    input logic     fill_rts,
    input logic     fill_rtr,
    input mem_req_t copy_req,
    input logic     copy_rts,
    input logic     copy_rtr,
    input client_t  bcast_xfc
);

    timeunit 1ns;
    timeprecision 100ps;

    client_t    rtr_vec;
    client_t    xfc;
    client_t    rd_xfc;
    logic       rd_now;
    logic [3:0] fetch_wait;

    assign rtr_vec = {copy_rtr, fill_rtr, fetch_rtr};
    assign xfc     = rtr_vec & {copy_rts, fill_rts, fetch_rts};

    // transfer that is a read, tagged with its client
    always_comb begin
        rd_now = (xfc[0] && fetch_req.wben == '0) ||
                 (xfc[1] && fill_req.wben == '0) ||
                 (xfc[2] && copy_req.wben == '0);
        rd_xfc = rd_now ? xfc : '0;
    end

    // cycles the fetcher has been waiting with rts up
    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            fetch_wait <= '0;
        end else if (fetch_rts && !fetch_rtr) begin
            fetch_wait <= (fetch_wait == '1) ? fetch_wait : fetch_wait + 1'b1;
        end else begin
            fetch_wait <= '0;
        end
    end

    a_rtr_onehot: assert property (@(posedge clk) disable iff (!rst_) $onehot0(rtr_vec))
        else $error("more than one client ready in the same cycle");

    a_xfc_onehot: assert property (@(posedge clk) disable iff (!rst_) $onehot0(bcast_xfc))
        else $error("read-back tag marks more than one client");

    // address registered one cycle, data back the next
    a_xfc_after_read: assert property (@(posedge clk) disable iff (!rst_)
        (bcast_xfc != '0) |-> (bcast_xfc == $past(rd_xfc, 2)))
        else $error("read-back tag without a matching read transfer");

    a_fetch_served: assert property (@(posedge clk) disable iff (!rst_)
        fetch_wait <= `FETCH_STARVE + 2)
        else $error("waiting fetcher was not granted in time");

endmodule

bind mem_arbiter gfx_checker chk_i (
    .clk(clk), .rst_(rst_),
    .fetch_req(fetch_req), .fetch_rts(fetch_rts), .fetch_rtr(fetch_rtr),
    .fill_req(fill_req), .fill_rts(fill_rts), .fill_rtr(fill_rtr),
    .copy_req(copy_req), .copy_rts(copy_rts), .copy_rtr(copy_rtr),
    .bcast_xfc(bcast_xfc)
);

//--- tb/gfx_tb.sv
`include "gfx_consts.svh"

module gfx_tb
    import mem_pkg::*;
    import cmd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // 32x32 window at the frame origin holds every pixel the tests touch
    localparam int WIN      = 32;
    localparam int WIN_PIX  = WIN * WIN;
    localparam int NUM_RUNS = 7;
    localparam int NUM_CMDS = 23;
    // each run reads back the whole window, plus one preload pass
    localparam int TIMEOUT_CYCLES = 12 * WIN_PIX * (NUM_RUNS + 1) + 40 * NUM_CMDS + 500;

    logic  clk;
    logic  rst_;
    logic  start;
    logic  busy;
    logic  done;
    logic  host_we;
    addr_t host_addr;
    data_t host_wdata;
    data_t host_rdata;

    // expected frame window, row major
    data_t     model [0:WIN_PIX-1];
    rect_cmd_t cmd_list [$];
    logic [31:0] rng_state;
    int        err_count = 0;
    int        cycle_count;
    string     cur_test;

    // read-back in flight, checked one cycle later
    logic  chk_valid;
    data_t chk_exp;
    addr_t chk_addr;

    gfx_top dut_i (
        .clk(clk), .rst_(rst_), .start(start), .busy(busy), .done(done),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 32-bit xorshift
    function automatic data_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic addr_t pixel_addr(input int x, input int y);
        return addr_t'(`FB_BASE + y * 256 + x);
    endfunction

    // walk the list in order like the hardware would, END stops it
    function automatic void apply_list();
        rect_cmd_t c;
        int        x;
        int        y;
        int        src;
        int        dst;
        logic      stop;
        stop = 1'b0;
        for (int n = 0; n < cmd_list.size(); n++) begin
            c = cmd_list[n];
            if (c.op == `OP_END) begin
                stop = 1'b1;
            end
            // unknown opcodes fall through both branches
            if (!stop && (c.op == `OP_FILL || c.op == `OP_COPY)) begin
                for (y = 0; y < int'(c.h); y++) begin
                    for (x = 0; x < int'(c.w); x++) begin
                        dst = (int'(c.dy) + y) * WIN + int'(c.dx) + x;
                        if (c.op == `OP_FILL) begin
                            model[dst] = c.arg;
                        end else begin
                            // copy reads the live model so overlap follows row order
                            src = (int'(c.arg[15:8]) + y) * WIN + int'(c.arg[7:0]) + x;
                            model[dst] = model[src];
                        end
                    end
                end
            end
        end
    endfunction

    task automatic check(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            err_count++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("Regression failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // each host task takes one cycle and drives 2 ns after the edge
    task automatic host_write(input addr_t a, input data_t d);
        @(posedge clk);
        #2;
        host_we    = 1'b1;
        host_addr  = a;
        host_wdata = d;
        chk_valid  = 1'b0;
    endtask

    task automatic host_read(input addr_t a, input data_t exp);
        @(posedge clk);
        #2;
        host_we   = 1'b0;
        host_addr = a;
        chk_addr  = a;
        chk_exp   = exp;
        chk_valid = 1'b1;
    endtask

    task automatic host_quiet();
        @(posedge clk);
        #2;
        host_we   = 1'b0;
        chk_valid = 1'b0;
    endtask

    task automatic push_cmd(input opcode_t op, input int dx, input int dy,
                            input int w, input int h, input data_t arg);
        rect_cmd_t c;
        c.op  = op;
        c.w   = coord_t'(w);
        c.h   = coord_t'(h);
        c.dx  = coord_t'(dx);
        c.dy  = coord_t'(dy);
        c.arg = arg;
        cmd_list.push_back(c);
    endtask

    task automatic add_fill(input int dx, input int dy, input int w, input int h,
                            input data_t colour);
        push_cmd(`OP_FILL, dx, dy, w, h, colour);
    endtask

    // source y and x go in the low half of the argument
    task automatic add_copy(input int sx, input int sy, input int dx, input int dy,
                            input int w, input int h);
        push_cmd(`OP_COPY, dx, dy, w, h, data_t'(sy * 256 + sx));
    endtask

    task automatic end_list();
        push_cmd(`OP_END, 0, 0, 0, 0, 32'h0);
    endtask

    // load list, run it, then compare the whole window with the model
    task automatic run_list(input string name);
        rect_cmd_t c;
        int        x;
        int        y;
        cur_test = name;
        apply_list();
        for (int n = 0; n < cmd_list.size(); n++) begin
            c = cmd_list[n];
            host_write(addr_t'(`CMD_BASE + 3 * n), {c.op, 12'h000, c.w, c.h});
            host_write(addr_t'(`CMD_BASE + 3 * n + 1), {16'h0000, c.dy, c.dx});
            host_write(addr_t'(`CMD_BASE + 3 * n + 2), c.arg);
        end
        host_quiet();
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        check({name, " busy after start"}, 32'd1, data_t'(busy));
        // busy must hold until the done pulse, done cycle included
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            check({name, " busy"}, 32'd1, data_t'(busy));
        end
        @(posedge clk);
        #1;
        check({name, " busy after done"}, 32'd0, data_t'(busy));
        for (y = 0; y < WIN; y++) begin
            for (x = 0; x < WIN; x++) begin
                host_read(pixel_addr(x, y), model[y * WIN + x]);
            end
        end
        host_quiet();
        cmd_list.delete();
    endtask

    // host_rdata is one cycle behind the address
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (chk_valid) begin
                check($sformatf("%s pixel %h", cur_test, chk_addr), chk_exp, host_rdata);
            end
        end
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("Regression failed");
        $fatal(1, "simulation stopped on timeout");
    end

    initial begin
        int    w;
        int    h;
        int    dx;
        int    dy;
        int    sx;
        int    sy;
        data_t v;
        rst_       = 1'b0;
        start      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        chk_valid  = 1'b0;
        chk_exp    = '0;
        chk_addr   = '0;
        rng_state  = 32'd35983;
        cur_test   = "reset";
        repeat (16) @(posedge clk);
        #2;
        rst_ = 1'b1;

        // random background in the window
        for (int i = 0; i < WIN_PIX; i++) begin
            v = next_random();
            model[i] = v;
            host_write(pixel_addr(i % WIN, i / WIN), v);
        end
        host_quiet();

        end_list();
        run_list("empty_list");

        add_fill(4, 5, 6, 3, next_random());
        end_list();
        run_list("single_fill");

        add_copy(2, 2, 20, 18, 5, 4);
        end_list();
        run_list("single_copy");

        // copy source overlaps the fill, so order matters
        add_fill(10, 10, 4, 4, next_random());
        add_copy(9, 9, 20, 2, 6, 6);
        end_list();
        run_list("fill_then_copy");

        for (int k = 0; k < 10; k++) begin
            w  = int'(next_random() % 9);
            h  = int'(next_random() % 9);
            dx = int'(next_random() % 24);
            dy = int'(next_random() % 24);
            sx = int'(next_random() % 24);
            sy = int'(next_random() % 24);
            // a few empty rectangles
            if (k == 3) begin
                w = 0;
            end
            if (k == 6) begin
                h = 0;
            end
            if (k == 8) begin
                push_cmd(4'd9, dx, dy, w, h, next_random());
            end else if ((next_random() & 32'd1) != 0) begin
                add_fill(dx, dy, w, h, next_random());
            end else begin
                add_copy(sx, sy, dx, dy, w, h);
            end
        end
        end_list();
        run_list("random_mix");

        // back to back runs without reset
        add_fill(0, 24, 8, 6, next_random());
        end_list();
        run_list("restart_first");
        add_copy(0, 24, 24, 24, 8, 6);
        end_list();
        run_list("restart_second");

        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
verilog/mem_pkg.sv
verilog/cmd_pkg.sv
verilog/cmd_fetch.sv
verilog/rect_fill.sv
verilog/rect_copy.sv
verilog/mem_arbiter.sv
verilog/frame_mem.sv
verilog/gfx_top.sv
tb/gfx_checker.sv
tb/gfx_tb.sv

//--- run.sh
#!/bin/sh
# build the gfx testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sources.f --top-module gfx_tb --Mdir "$BUILD_DIR" -o gfx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/gfx_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
else
    echo "pass line not found in $LOG"
    exit 1
fi
